//--- fx2fp_pkg.sv
//******************************
// Shared widths and types for the fixed-point to IEEE 754 converter.
// Single precision only. The exponent layout has no other width.
// No rounding, denormals, infinities or NaN are produced.
// Fraction bit 31 carries a weight of one half.
//******************************

package fx2fp_pkg;

    // operand layout.
    localparam int INT_BITS  = 32;
    localparam int FRAC_BITS = 32;
    localparam int MAG_BITS  = INT_BITS + FRAC_BITS;

    // single precision layout.
    localparam int EXP_BITS  = 8;
    localparam int MANT_BITS = 23;
    localparam int EXP_BIAS  = 127;

    typedef logic [INT_BITS-1:0]          int_part_t;   // integer part of the operand.
    typedef logic [FRAC_BITS-1:0]         frac_part_t;  // fraction part, msb weighs one half.
    typedef logic [MAG_BITS-1:0]          fixed_mag_t;  // integer part above fraction part.
    typedef logic [$clog2(MAG_BITS)-1:0]  lead_pos_t;   // bit index inside fixed_mag_t.
    typedef logic [EXP_BITS-1:0]          fp_exp_t;     // biased exponent.
    typedef logic [MANT_BITS-1:0]         fp_mant_t;    // stored mantissa, hidden one dropped.

    // Signed fixed-point operand as it enters the converter.
    typedef struct packed {
        logic       sign;
        int_part_t  int_part;
        frac_part_t frac_part;
    } fixed_in_t;

    // Stage one register contents.
    // pos is only meaningful while zero is low.
    typedef struct packed {
        logic       valid;
        logic       sign;
        logic       zero;
        lead_pos_t  pos;
        fixed_mag_t mag;
    } lead_info_t;

    // IEEE 754 single precision word in its bus order.
    typedef struct packed {
        logic     sign;
        fp_exp_t  exp;
        fp_mant_t mant;
    } fp_word_t;

endpackage : fx2fp_pkg

//--- fx2fp_tb.sv
//******************************
// Testbench for the fixed-point to single precision converter.
// Inputs change on the falling edge and outputs are sampled there too.
// Expected words are {zero flag, IEEE word}, 33 bits wide.
// Random operands come from a 32-bit LFSR with a fixed seed.
//******************************

module fx2fp_tb;

    import fx2fp_pkg::*;

    localparam int RANDOM_ITEMS = 200;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    fixed_in_t  operand;
    logic       out_valid;
    fp_word_t   result;
    logic       out_is_zero;

    logic [32:0] exp_q[$];
    string       name_q[$];
    string       test_name;
    logic [31:0] lfsr_state = 32'h69ee;
    int          stim_errors = 0;
    int          stim_checks = 0;
    int          compare_errors = 0;
    int          compare_checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fx2fp_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .operand     (operand),
        .out_valid   (out_valid),
        .result      (result),
        .out_is_zero (out_is_zero)
    );

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        repeat (count) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Expected {zero, word} straight from the conversion rules.
    function automatic logic [32:0] ref_convert(input fixed_in_t op);
        logic [63:0] mag;
        logic [22:0] mant;
        logic [7:0]  exp_bits;
        int          lead;
        int          idx;
        mag  = {op.int_part, op.frac_part};
        lead = -1;
        for (int i = 63; i >= 0; i--) begin
            if (lead < 0 && mag[i]) begin
                lead = i;
            end
        end
        if (lead < 0) begin
            return {1'b1, op.sign, 31'd0};
        end
        mant = '0;
        for (int b = 0; b < 23; b++) begin
            idx = lead - 1 - b;
            if (idx >= 0) begin
                mant[22-b] = mag[idx]; // bits below bit 0 stay zero.
            end
        end
        exp_bits = 8'(lead - 32 + 127);
        return {1'b0, op.sign, exp_bits, mant};
    endfunction

    // Each result is matched against the oldest expected item.
    always @(negedge clk) begin : compare_proc
        logic [32:0] expected;
        logic [32:0] actual;
        string       name;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid pulsed while no result was expected");
                compare_errors++;
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                actual   = {out_is_zero, result};
                compare_checks++;
                assert (actual == expected) else begin
                    $display("[ERROR] %s: expected %h zero %b, actual %h zero %b",
                             name, expected[31:0], expected[32], actual[31:0], actual[32]);
                    compare_errors++;
                end
            end
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = stim_errors + compare_errors;
    endtask

    task automatic finish_test();
        int new_errors;
        new_errors = stim_errors + compare_errors - errors_at_start;
        tests_run++;
        if (new_errors > 0) begin
            tests_failed++;
        end
        $display("test %-18s finished with %0d errors", test_name, new_errors);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 16) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out in %s with %0d results never returned", test_name, exp_q.size());
            stim_errors++;
        end
    endtask

    // One operand alone, also checking that out_valid comes two cycles later.
    task automatic send_timed(input fixed_in_t op, input logic [32:0] expected);
        int cycles;
        in_valid = 1'b1;
        operand  = op;
        exp_q.push_back(expected);
        name_q.push_back(test_name);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            in_valid = 1'b0;
        end while (!out_valid && cycles < 8);
        if (!out_valid) begin
            $display("timed out in %s waiting for out_valid", test_name);
            stim_errors++;
        end else begin
            stim_checks++;
            assert (cycles == 2) else begin
                $display("[ERROR] %s latency: expected 2, actual %0d", test_name, cycles);
                stim_errors++;
            end
        end
        wait_drain();
    endtask

    initial begin : stimulus_proc
        logic [31:0] r_sign;
        logic [31:0] r_sel;
        logic [31:0] r_int;
        logic [31:0] r_frac;
        logic [31:0] r_width;
        fixed_in_t   op;
        int          width;
        int          cycles;
        in_valid = 1'b0;
        operand  = '0;

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("timed out waiting for reset release");
            stim_errors++;
        end

        start_test("idle_after_reset");
        repeat (10) begin
            @(negedge clk);
            stim_checks++;
            assert (out_valid == 1'b0) else begin
                $display("[ERROR] %s: expected out_valid 0, actual %b", test_name, out_valid);
                stim_errors++;
            end
        end
        finish_test();

        start_test("integer_only");
        send_timed('{1'b0, 32'h0000_0001, 32'h0}, {1'b0, 32'h3F80_0000});
        send_timed('{1'b1, 32'h8000_0000, 32'h0}, {1'b0, 32'hCF00_0000});
        send_timed('{1'b0, 32'h0000_0003, 32'h0}, {1'b0, 32'h4040_0000});
        send_timed('{1'b1, 32'h0000_0005, 32'h0}, {1'b0, 32'hC0A0_0000});
        send_timed('{1'b0, 32'hFFFF_FFFF, 32'h0}, {1'b0, 32'h4F7F_FFFF}); // truncated.
        send_timed('{1'b0, 32'h0000_0001, 32'h8000_0000}, {1'b0, 32'h3FC0_0000});
        finish_test();

        start_test("fraction_only");
        send_timed('{1'b0, 32'h0, 32'h8000_0000}, {1'b0, 32'h3F00_0000});
        send_timed('{1'b0, 32'h0, 32'hC000_0000}, {1'b0, 32'h3F40_0000});
        send_timed('{1'b0, 32'h0, 32'h0000_0001}, {1'b0, 32'h2F80_0000}); // exponent 95.
        finish_test();

        start_test("zero_operand");
        send_timed('{1'b0, 32'h0, 32'h0}, {1'b1, 32'h0000_0000});
        send_timed('{1'b1, 32'h0, 32'h0}, {1'b1, 32'h8000_0000});
        finish_test();

        // back to back operands, half of them with the integer part cleared.
        start_test("random_stream");
        for (int n = 0; n < RANDOM_ITEMS; n++) begin
            take_bits(1, r_sign);
            take_bits(1, r_sel);
            take_bits(32, r_int);
            take_bits(32, r_frac);
            take_bits(5, r_width);
            width = int'(r_width) + 1;
            op.sign      = r_sign[0];
            op.frac_part = r_frac;
            if (r_sel[0]) begin
                op.int_part  = '0;
                op.frac_part = r_frac >> r_width; // moves the leading one down.
            end else if (width == 32) begin
                op.int_part = r_int;
            end else begin
                op.int_part = r_int & ((32'd1 << width) - 32'd1);
            end
            in_valid = 1'b1;
            operand  = op;
            exp_q.push_back(ref_convert(op));
            name_q.push_back(test_name);
            @(negedge clk);
        end
        in_valid = 1'b0;
        wait_drain();
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, stim_checks + compare_checks,
                 stim_errors + compare_errors);
        if (stim_errors + compare_errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : fx2fp_tb

//--- fx2fp_top.sv
//******************************
// Fixed-point to IEEE 754 single precision converter.
// Fixed latency of two cycles from in_valid to out_valid.
// Two operands may be in flight. Results leave in input order.
// No handshake. Every out_valid pulse must be taken by the receiver.
//******************************

module fx2fp_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  fx2fp_pkg::fixed_in_t  operand,
    output logic                  out_valid,
    output fx2fp_pkg::fp_word_t   result,
    output logic                  out_is_zero
);

    import fx2fp_pkg::*;

    lead_info_t stage1; // registered leading-one information.

    lead_one_detect lead_one_detect_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .operand  (operand),
        .stage1   (stage1)
    );

    norm_pack norm_pack_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage1      (stage1),
        .out_valid   (out_valid),
        .result      (result),
        .out_is_zero (out_is_zero)
    );

endmodule : fx2fp_top

//--- lead_one_detect.sv
//******************************
// First pipeline stage of the converter.
// Registers the operand together with the position of its leading one.
// in_valid is a one-cycle strobe. A new operand may come every cycle.
// There is no back-pressure.
// Only stage1.valid is cleared by rst_n.
//******************************

module lead_one_detect (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  fx2fp_pkg::fixed_in_t   operand,
    output fx2fp_pkg::lead_info_t  stage1
);

    import fx2fp_pkg::*;

    fixed_mag_t mag_c;
    lead_pos_t  pos_c;
    logic       zero_c;

    // One search over both parts replaces separate integer and fraction searches.
    assign mag_c  = {operand.int_part, operand.frac_part};
    assign zero_c = ~|mag_c;

    // Priority search. A higher set bit overrides any lower one found before it,
    // so the loop ends with the index of the most significant one.
    always_comb begin
        pos_c = '0;
        for (int i = 0; i < MAG_BITS; i++) begin
            if (mag_c[i]) begin
                pos_c = lead_pos_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage1.valid <= 1'b0;
        end else begin
            stage1.valid <= in_valid;
        end
    end

    // Payload follows every cycle and is ignored while valid is low.
    always_ff @(posedge clk) begin
        stage1.sign <= operand.sign;
        stage1.zero <= zero_c;
        stage1.pos  <= pos_c;
        stage1.mag  <= mag_c;
    end

    // The registered position must point at a set bit of the registered magnitude.
    a_lead_bit_set : assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage1.valid && !stage1.zero) |-> stage1.mag[stage1.pos]
    );

    // No set bit may sit above the registered position.
    a_lead_bit_top : assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage1.valid && !stage1.zero) |-> ((stage1.mag >> stage1.pos) == fixed_mag_t'(1))
    );

endmodule : lead_one_detect

//--- norm_pack.sv
//******************************
// Second pipeline stage of the converter.
// Normalizes the magnitude and registers the packed single precision word.
// The mantissa is truncated, never rounded. Missing low bits are zero.
// A zero operand gives the sign bit alone and out_is_zero high.
// Only out_valid is cleared by rst_n.
//******************************

module norm_pack (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fx2fp_pkg::lead_info_t  stage1,
    output logic                   out_valid,
    output fx2fp_pkg::fp_word_t    result,
    output logic                   out_is_zero
);

    import fx2fp_pkg::*;

    lead_pos_t  shift_c;
    fixed_mag_t aligned_c;
    fp_exp_t    exp_c;
    fp_mant_t   mant_c;
    fp_word_t   word_c;

    // 63 - pos moves the leading one to the msb. In six bits that is the inverse of pos.
    assign shift_c   = ~stage1.pos;
    assign aligned_c = stage1.mag << shift_c;

    // the leading one is the hidden bit, so the mantissa starts just below it.
    assign mant_c = aligned_c[MAG_BITS-2 -: MANT_BITS];

    // pos runs 0 to 63, so the biased exponent stays between 95 and 158.
    assign exp_c = fp_exp_t'(stage1.pos) + fp_exp_t'(EXP_BIAS - FRAC_BITS);

    always_comb begin
        word_c.sign = stage1.sign; // sign passes through even for zero.
        if (stage1.zero) begin
            word_c.exp  = '0;
            word_c.mant = '0;
        end else begin
            word_c.exp  = exp_c;
            word_c.mant = mant_c;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= stage1.valid;
        end
    end

    always_ff @(posedge clk) begin
        result      <= word_c;
        out_is_zero <= stage1.zero;
    end

    // A zero result carries nothing but the sign.
    a_zero_word : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_is_zero |-> (result.exp == '0 && result.mant == '0)
    );

    // Nothing leaves the pipeline in the first cycle out of reset.
    a_reset_quiet : assert property (
        @(posedge clk)
        $past(!rst_n) |-> !out_valid
    );

endmodule : norm_pack

//--- project.f
fx2fp_pkg.sv
lead_one_detect.sv
norm_pack.sv
fx2fp_top.sv
tb_clk_gen.sv
fx2fp_tb.sv

//--- run.sh
#!/bin/sh
# Builds the converter testbench with Verilator and runs it.
# The exit status is zero only when the pass line appears in the output.

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f project.f --top-module fx2fp_tb -o fx2fp_sim \
    && ./obj_dir/fx2fp_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_clk_gen.sv
//******************************
// Testbench clock and reset source.
// Clock period is 40 time units.
// rst_n stays low for 16 rising edges.
// It is released on a falling edge.
//******************************

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released away from the sampling edge.
    end

endmodule : tb_clk_gen
